// File: sim.f
src/seg_pkg.sv
src/display_regs.sv
src/bin_to_bcd.sv
src/seg_decoder.sv
src/digit_scanner.sv
src/seg_display_top.sv
verification/tb_seg_display.sv

// File: verification/tb_seg_display.sv
`timescale 1ns/1ps

module tb_seg_display import seg_pkg::*; ();

	localparam int SCAN_DIV = 8;
	localparam int SCAN_LEN = 4 * SCAN_DIV;
	localparam int N_RDBK = 8;	// CTRL and DATA readback rounds
	localparam int N_BIN = 40;
	localparam int N_RAW = 20;
	localparam int N_OPS = N_RDBK + N_BIN + N_RAW + 8;	// Plus reset, status and disable steps
	localparam int OP_CYCLES = 2 * SCAN_LEN + 48;	// Write, 20 status reads and a two-scan watch
	localparam int CYCLE_LIMIT = 2 * N_OPS * OP_CYCLES;

	logic              clk;
	logic              rst;
	wb_req_t           wb_req;
	wb_rsp_t           wb_rsp;
	logic [3:0]        anode_n;
	seg_t              seg;
	logic [31:0]       lfsr = 32'h6e4e_0931;
	int                errors = 0;
	int                checks = 0;
	int                cycle_cnt = 0;
	logic              m_raw;	// Model of the control and data registers
	logic [31:0]       m_data;
	logic signed [7:0] m_last;	// Last value sent to the converter
	logic [31:0]       rd;
	logic [31:0]       w;
	logic signed [7:0] v;
	int                lit;
	int                cur_dig;
	int                run_len;
	bit                run_full;

	seg_display_top #(
		.SCAN_DIV (SCAN_DIV)
	) dut0 (
		.clk     (clk),
		.rst     (rst),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.anode_n (anode_n),
		.seg     (seg)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT)
		begin
			$display("Run stopped after %0d cycles without reaching the end", cycle_cnt);
			$display("test failed");
			$finish;
		end
	end

	// ************************************************************
	// Stimulus source and display model
	// ************************************************************

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic seg_t digit_pattern(input int d);
		case (d)
			0: return 7'h3F;
			1: return 7'h06;
			2: return 7'h5B;
			3: return 7'h4F;
			4: return 7'h66;
			5: return 7'h6D;
			6: return 7'h7D;
			7: return 7'h07;
			8: return 7'h7F;
			9: return 7'h6F;
			default: return 7'h00;
		endcase
	endfunction

	function automatic seg_t expected_seg(input int d);
		int mag;
		mag = (m_last < 0) ? -int'(m_last) : int'(m_last);
		if (m_raw)
			return m_data[7*d +: 7];
		case (d)
			3: return (m_last < 0) ? 7'h40 : 7'h00;	// Minus lights g alone
			2: return digit_pattern(mag / 100);
			1: return digit_pattern((mag / 10) % 10);
			default: return digit_pattern(mag % 10);
		endcase
	endfunction

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("** Error at %0t ns: %s, got %h, expected %h", $time, what, actual,
				expected);
		end
	endtask

	// ************************************************************
	// Bus access
	// ************************************************************

	task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int waited;
		wb_req.cyc   = 1'b1;
		wb_req.stb   = 1'b1;
		wb_req.we    = we;
		wb_req.adr   = adr;
		wb_req.dat_w = wdat;
		rdat = '0;
		waited = 0;
		do
		begin
			@(posedge clk);
			#1;
			waited++;
		end while (!wb_rsp.ack && waited < 4);
		if (wb_rsp.ack)
			rdat = wb_rsp.dat_r;
		else
		begin
			errors++;
			$display("Bus access to address %0d got no ack within 4 cycles", adr);
		end
		@(posedge clk);	// The request stays up over the edge that samples ack
		#1;
		wb_req = '0;
	endtask

	task automatic write_reg(input logic [1:0] adr, input logic [31:0] dat);
		logic [31:0] ignored;
		bus_access(1'b1, adr, dat, ignored);
		if (adr == REG_CTRL)
			m_raw = dat[1];
		else if (adr == REG_DATA)
		begin
			if (!m_raw)
				m_last = dat[7:0];
			m_data = dat;
		end
	endtask

	task automatic read_reg(input logic [1:0] adr, output logic [31:0] dat);
		bus_access(1'b0, adr, 32'd0, dat);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		int polls;
		polls = 0;
		do
		begin
			read_reg(REG_STATUS, st);
			polls++;
		end while (st[0] && polls < 20);
		if (st[0])
		begin
			errors++;
			$display("Converter still busy after %0d status reads", polls);
		end
		else
			compare(st, 32'd0, "STATUS once idle");
		wait_cycles(2);	// Loaded digits reach the output register
	endtask

	// ************************************************************
	// Display watching
	// ************************************************************

	task automatic watch_scans(input int n);
		logic [3:0] seen;
		seen = '0;
		repeat (n * SCAN_LEN)
		begin
			@(negedge clk);
			for (int d = 0; d < 4; d++)
				if (anode_n == ~(4'b0001 << d))
				begin
					seen[d] = 1'b1;
					compare(seg, expected_seg(d), $sformatf("segments of digit %0d", d));
				end
		end
		compare(seen, 4'hF, "digits lit while watching");
		@(posedge clk);
		#1;
	endtask

	task automatic expect_dark(input int n);
		repeat (n)
		begin
			@(negedge clk);
			compare(anode_n, 4'hF, "anode_n while disabled");
		end
		@(posedge clk);
		#1;
	endtask

	// Scan order, exclusivity and lit time over the whole run
	always @(negedge clk)
	begin
		if (!rst)
		begin
			lit = -1;
			for (int d = 0; d < 4; d++)
				if (anode_n == ~(4'b0001 << d))
					lit = d;
			compare($countones(~anode_n) > 1, 0, "several anodes low at once");
			if (lit < 0)
				cur_dig = -1;
			else if (cur_dig < 0)
			begin
				cur_dig  = lit;
				run_len  = 1;
				run_full = 0;	// First run after dark may be cut short
			end
			else if (lit == cur_dig)
			begin
				run_len++;
				if (run_len > SCAN_DIV)
					compare(run_len, SCAN_DIV, "cycles a digit stays lit");
			end
			else
			begin
				compare(lit, (cur_dig + 3) % 4, "digit following the previous one");
				if (run_full)
					compare(run_len, SCAN_DIV, "cycles a digit stays lit");
				cur_dig  = lit;
				run_len  = 1;
				run_full = 1;
			end
		end
	end

	// ************************************************************
	// Test sequence
	// ************************************************************

	initial
	begin
		wb_req   = '0;
		rst      = 1'b1;
		m_raw    = 1'b0;
		m_data   = '0;
		m_last   = '0;
		cur_dig  = -1;
		run_len  = 0;
		run_full = 0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		compare(anode_n, 4'hF, "anode_n after reset");
		compare(seg, 32'd0, "seg after reset");
		expect_dark(SCAN_LEN);

		for (int i = 0; i < N_RDBK; i++)
		begin
			w = take_bits(32);
			write_reg(REG_CTRL, w);
			read_reg(REG_CTRL, rd);
			compare(rd, w & 32'h3, "CTRL readback");
			w = take_bits(32);
			write_reg(REG_DATA, w);
			read_reg(REG_DATA, rd);
			compare(rd, w, "DATA readback");
		end
		write_reg(REG_CTRL, 32'h0);
		write_reg(REG_DATA, take_bits(32));
		read_reg(REG_STATUS, rd);
		compare(rd, 32'd1, "STATUS during a conversion");
		wait_idle();
		write_reg(REG_STATUS, 32'hFFFF_FFFF);
		read_reg(REG_STATUS, rd);
		compare(rd, 32'd0, "STATUS after a write to it");
		read_reg(2'd3, rd);
		compare(rd, 32'd0, "address 3");

		write_reg(REG_CTRL, 32'h1);	// Enabled in binary mode
		for (int i = 0; i < N_BIN; i++)
		begin
			case (i)
				0: v = 8'h80;
				1: v = 8'hFF;
				2: v = 8'h00;
				3: v = 8'h7F;
				default: v = take_bits(8);
			endcase
			w = take_bits(24);
			write_reg(REG_DATA, {w[23:0], v});
			wait_idle();
			watch_scans(2);
		end

		write_reg(REG_CTRL, 32'h3);	// Raw mode leaves the converted digits alone
		for (int i = 0; i < N_RAW; i++)
		begin
			write_reg(REG_DATA, take_bits(28));
			wait_cycles(2);
			watch_scans(2);
		end

		write_reg(REG_CTRL, 32'h1);
		wait_cycles(2);
		watch_scans(1);
		write_reg(REG_CTRL, 32'h0);
		expect_dark(SCAN_LEN);
		write_reg(REG_CTRL, 32'h1);
		wait_cycles(2);
		watch_scans(2);

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: src/seg_display_top.sv
`timescale 1ns/1ps

module seg_display_top import seg_pkg::*; #(
	parameter int SCAN_DIV = 65536	// Clock cycles per lit digit
) (
	input  logic       clk,
	input  logic       rst,
	input  wb_req_t    wb_req,
	output wb_rsp_t    wb_rsp,
	output logic [3:0] anode_n,
	output seg_t       seg
);

	logic              busy;
	logic              start;
	logic              done;
	logic signed [7:0] value;
	ctrl_t             ctrl;
	display_word_u     data;
	bcd_digits_t       digits;

	// ************************************************************
	// Bus registers, converter and scanner
	// ************************************************************

	display_regs u_regs (
		.clk    (clk),
		.rst    (rst),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.busy   (busy),
		.start  (start),
		.value  (value),
		.ctrl   (ctrl),
		.data   (data)
	);

	bin_to_bcd u_bcd (
		.clk    (clk),
		.rst    (rst),
		.start  (start),
		.value  (value),
		.busy   (busy),
		.done   (done),
		.digits (digits)
	);

	digit_scanner #(
		.SCAN_DIV (SCAN_DIV)
	) u_scan (
		.clk     (clk),
		.rst     (rst),
		.ctrl    (ctrl),
		.data    (data),
		.done    (done),
		.digits  (digits),
		.anode_n (anode_n),
		.seg     (seg)
	);

endmodule

// File: src/digit_scanner.sv
`timescale 1ns/1ps

module digit_scanner import seg_pkg::*; #(
	parameter int SCAN_DIV = 65536
) (
	input  logic          clk,
	input  logic          rst,
	input  ctrl_t         ctrl,
	input  display_word_u data,
	input  logic          done,
	input  bcd_digits_t   digits,
	output logic [3:0]    anode_n,
	output seg_t          seg
);

	localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

	bcd_digits_t      shown;	// Digits from the last finished conversion
	logic [CNT_W-1:0] pre_cnt;
	logic [1:0]       idx;
	logic [3:0]       code;
	seg_t             dec_pattern;
	seg_t             raw_pattern;
	seg_t             next_seg;
	logic [3:0]       next_anode_n;

	// ************************************************************
	// Prescaler and digit index
	// ************************************************************

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pre_cnt <= '0;
			idx     <= 2'd3;	// Leftmost digit first
			shown   <= '0;
		end
		else
		begin
			if (pre_cnt == CNT_W'(SCAN_DIV - 1))
			begin
				pre_cnt <= '0;
				idx     <= idx - 2'd1;	// 3, 2, 1, 0 and around
			end
			else
				pre_cnt <= pre_cnt + 1'b1;
			if (done)
				shown <= digits;
		end
	end

	// ************************************************************
	// Digit selection
	// ************************************************************

	always_comb
	begin
		case (idx)
			2'd3:    code = shown.sign ? CODE_MINUS : CODE_BLANK;
			2'd2:    code = shown.hundreds;
			2'd1:    code = shown.tens;
			default: code = shown.ones;
		endcase
	end

	always_comb
	begin
		case (idx)
			2'd3:    raw_pattern = data.raw.digit3;
			2'd2:    raw_pattern = data.raw.digit2;
			2'd1:    raw_pattern = data.raw.digit1;
			default: raw_pattern = data.raw.digit0;
		endcase
	end

	seg_decoder u_dec (
		.code    (code),
		.pattern (dec_pattern)
	);

	assign next_seg     = ctrl.raw_mode ? raw_pattern : dec_pattern;
	assign next_anode_n = ~(4'b0001 << idx);

	// Anode and pattern leave on the same edge
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			anode_n <= 4'hF;
			seg     <= SEG_BLANK;
		end
		else if (!ctrl.enable)
		begin
			anode_n <= 4'hF;
			seg     <= SEG_BLANK;
		end
		else
		begin
			anode_n <= next_anode_n;
			seg     <= next_seg;
		end
	end

	a_one_anode: assert property (@(posedge clk) disable iff (rst)
		$onehot0(~anode_n))
		else $error("more than one anode enabled");

endmodule

// File: src/seg_decoder.sv
`timescale 1ns/1ps

module seg_decoder import seg_pkg::*; (
	input  logic [3:0] code,
	output seg_t       pattern
);

	// Patterns listed as g f e d c b a
	always_comb
	begin
		case (code)
			4'd0:       pattern = 7'b011_1111;
			4'd1:       pattern = 7'b000_0110;
			4'd2:       pattern = 7'b101_1011;
			4'd3:       pattern = 7'b100_1111;
			4'd4:       pattern = 7'b110_0110;
			4'd5:       pattern = 7'b110_1101;
			4'd6:       pattern = 7'b111_1101;
			4'd7:       pattern = 7'b000_0111;
			4'd8:       pattern = 7'b111_1111;
			4'd9:       pattern = 7'b110_1111;
			CODE_MINUS: pattern = SEG_MINUS;
			default:    pattern = SEG_BLANK;	// CODE_BLANK and unused codes
		endcase
	end

endmodule

// File: src/bin_to_bcd.sv
`timescale 1ns/1ps

module bin_to_bcd import seg_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  logic signed [7:0] value,
	output logic              busy,
	output logic              done,
	output bcd_digits_t       digits
);

	// Three BCD nibbles above the eight magnitude bits
	logic [19:0] shift_q;
	logic [19:0] shift_next;
	logic [2:0]  step_cnt;
	logic        sign_q;
	logic [7:0]  mag;

	// The two's complement magnitude of 8'h80 stays 128 as unsigned
	assign mag = value[7] ? (~value + 8'd1) : value;

	// One shift-and-add-3 step over the whole register
	function automatic logic [19:0] dabble_step(input logic [19:0] s);
		logic [19:0] t;
		t = s;
		if (t[19:16] >= 4'd5)
			t[19:16] = t[19:16] + 4'd3;
		if (t[15:12] >= 4'd5)
			t[15:12] = t[15:12] + 4'd3;
		if (t[11:8] >= 4'd5)
			t[11:8] = t[11:8] + 4'd3;
		return {t[18:0], 1'b0};
	endfunction

	assign shift_next = dabble_step(shift_q);

	// ************************************************************
	// Sequencer
	// ************************************************************

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			busy     <= 1'b0;
			done     <= 1'b0;
			step_cnt <= 3'd0;
			digits   <= '0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				busy     <= 1'b1;	// A start while busy begins again
				step_cnt <= 3'd0;
			end
			else if (busy)
			begin
				step_cnt <= step_cnt + 3'd1;
				if (step_cnt == 3'd7)
				begin
					// The eighth step ends eight cycles after the load
					busy            <= 1'b0;
					done            <= 1'b1;
					digits.sign     <= sign_q;
					digits.hundreds <= shift_next[19:16];
					digits.tens     <= shift_next[15:12];
					digits.ones     <= shift_next[11:8];
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			shift_q <= {12'd0, mag};
			sign_q  <= value[7];
		end
		else if (busy)
			shift_q <= shift_next;
	end

	a_digits_decimal: assert property (@(posedge clk) disable iff (rst)
		done |-> (digits.hundreds <= 4'd9 && digits.tens <= 4'd9 && digits.ones <= 4'd9))
		else $error("converter produced a digit above 9");

endmodule

// File: src/display_regs.sv
`timescale 1ns/1ps

module display_regs import seg_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  wb_req_t           wb_req,
	output wb_rsp_t           wb_rsp,
	input  logic              busy,
	output logic              start,
	output logic signed [7:0] value,
	output ctrl_t             ctrl,
	output display_word_u     data
);

	logic        ack_q;
	logic [31:0] dat_r_q;
	logic [31:0] rd_mux;
	logic        access;	// First cycle of a request
	logic        wr_ctrl;
	logic        wr_data;

	// A request is served once, the cycle before its ack
	assign access  = wb_req.cyc && wb_req.stb && !ack_q;
	assign wr_ctrl = access && wb_req.we && (wb_req.adr == REG_CTRL);
	assign wr_data = access && wb_req.we && (wb_req.adr == REG_DATA);

	always_comb
	begin
		case (wb_req.adr)
			REG_CTRL:   rd_mux = {30'd0, ctrl};
			REG_DATA:   rd_mux = data;
			REG_STATUS: rd_mux = {31'd0, busy};
			default:    rd_mux = 32'd0;
		endcase
	end

	// ************************************************************
	// Control state
	// ************************************************************

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			ack_q <= 1'b0;
			start <= 1'b0;
			ctrl  <= '0;
			data  <= '0;
		end
		else
		begin
			ack_q <= access;
			// Start lines up with the ack of a binary-mode data write
			start <= wr_data && !ctrl.raw_mode;
			if (wr_ctrl)
				ctrl <= ctrl_t'(wb_req.dat_w[1:0]);
			if (wr_data)
				data <= wb_req.dat_w;
		end
	end

	always_ff @(posedge clk)
	begin
		if (access)
			dat_r_q <= rd_mux;	// Held until the next request
	end

	// The data register is already updated when start is high
	assign value = data.bin.value;

	assign wb_rsp.ack   = ack_q;
	assign wb_rsp.dat_r = dat_r_q;

	// The host keeps its request up until it sees ack
	a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
		ack_q |-> (wb_req.cyc && wb_req.stb))
		else $error("ack high without cyc and stb");

endmodule

// File: src/seg_pkg.sv
package seg_pkg;

	// ************************************************************
	// Wishbone classic request and response
	// ************************************************************

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [1:0]  adr;	// Word address
		logic [31:0] dat_w;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat_r;
	} wb_rsp_t;

	// ************************************************************
	// Display data
	// ************************************************************

	typedef logic [6:0] seg_t;	// Bit 0 is segment a, bit 6 is segment g

	typedef union packed {
		struct packed {
			logic [23:0]        unused;
			logic signed [7:0]  value;
		} bin;
		struct packed {
			logic [3:0] spare;
			seg_t       digit3;
			seg_t       digit2;
			seg_t       digit1;
			seg_t       digit0;
		} raw;
	} display_word_u;

	typedef struct packed {
		logic       sign;
		logic [3:0] hundreds;
		logic [3:0] tens;
		logic [3:0] ones;
	} bcd_digits_t;

	typedef struct packed {
		logic raw_mode;
		logic enable;	// Lands on bit 0 of the CTRL word
	} ctrl_t;

	localparam logic [1:0] REG_CTRL   = 2'd0;
	localparam logic [1:0] REG_DATA   = 2'd1;
	localparam logic [1:0] REG_STATUS = 2'd2;

	localparam seg_t SEG_MINUS = 7'b100_0000;
	localparam seg_t SEG_BLANK = 7'b000_0000;

	// Decoder codes above the decimal range
	localparam logic [3:0] CODE_MINUS = 4'd10;
	localparam logic [3:0] CODE_BLANK = 4'd15;

endpackage
